// ==== build.f ====
+incdir+src
src/graph_cu_pkg.sv
src/sync_fifo.sv
src/round_robin_arbiter.sv
src/job_dispatcher.sv
src/vertex_cu.sv
src/read_command_port.sv
src/read_data_router.sv
src/graph_cu_control.sv
verification/graph_cu_control_tb.sv

// ==== src/graph_cu_config.svh ====
//////////////////////////////////////////////////
// Sizing macros for the graph-engine control unit
// Unit count, field widths and job buffer depth
//////////////////////////////////////////////////

`ifndef GRAPH_CU_CONFIG_SVH
`define GRAPH_CU_CONFIG_SVH

// Compute units
`define NUM_CU            4
`define CU_ID_BITS        2

// Job and memory fields
`define VERTEX_ID_BITS    16
`define EDGE_COUNT_BITS   8
`define ADDR_BITS         32
`define DATA_BITS         32
`define COUNT_BITS        16

// Vertex job buffer
`define JOB_FIFO_DEPTH    8
`define JOB_FIFO_HEADROOM 2

`endif

// ==== src/graph_cu_control.sv ====
//////////////////////////////////////////////////
// Graph-engine control unit top
// Enable register, units, memory ports, done sums
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "graph_cu_config.svh"

module graph_cu_control
	import graph_cu_pkg::*;
(
	input  logic                 clock,
	input  logic                 rstn,
	input  logic                 enabled_in,
	input  logic [`CU_ID_BITS:0] active_cu_count,
	input  logic                 job_valid,
	input  vertex_id_t           job_vertex_id,
	input  addr_t                job_edge_base,
	input  edge_count_t          job_edge_count,
	output logic                 job_request,
	input  logic                 read_stall,
	output logic                 read_cmd_valid,
	output cu_id_t               read_cmd_cu_id,
	output addr_t                read_cmd_address,
	input  logic                 read_data_valid,
	input  cu_id_t               read_data_cu_id,
	input  data_t                read_data_value,
	output count_t               vertex_done_count,
	output count_t               edge_done_count
);
	logic               enabled;
	logic [`NUM_CU-1:0] cu_job_valid;
	vertex_id_t         cu_job_vertex_id;
	addr_t              cu_job_edge_base;
	edge_count_t        cu_job_edge_count;
	logic [`NUM_CU-1:0] cu_job_request;
	logic [`NUM_CU-1:0] cu_cmd_request;
	addr_t              cu_cmd_address [`NUM_CU];
	logic [`NUM_CU-1:0] cu_cmd_grant;
	logic [`NUM_CU-1:0] cu_data_valid;
	count_t             cu_vertex_count [`NUM_CU];
	count_t             cu_edge_count [`NUM_CU];
	count_t             vertex_sum;
	count_t             edge_sum;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled <= 1'b0;
		end else begin
			enabled <= enabled_in;
		end
	end

	job_dispatcher dispatcher (
		.clock             (clock),
		.rstn              (rstn),
		.enabled           (enabled),
		.active_cu_count   (active_cu_count),
		.job_valid         (job_valid),
		.job_vertex_id     (job_vertex_id),
		.job_edge_base     (job_edge_base),
		.job_edge_count    (job_edge_count),
		.cu_job_request    (cu_job_request),
		.job_request       (job_request),
		.cu_job_valid      (cu_job_valid),
		.cu_job_vertex_id  (cu_job_vertex_id),
		.cu_job_edge_base  (cu_job_edge_base),
		.cu_job_edge_count (cu_job_edge_count)
	);

	for (genvar i = 0; i < `NUM_CU; i++) begin : gen_cu
		vertex_cu cu (
			.clock          (clock),
			.rstn           (rstn),
			.job_valid      (cu_job_valid[i]),
			.job_vertex_id  (cu_job_vertex_id),
			.job_edge_base  (cu_job_edge_base),
			.job_edge_count (cu_job_edge_count),
			.cmd_grant      (cu_cmd_grant[i]),
			.data_valid     (cu_data_valid[i]),
			.job_request    (cu_job_request[i]),
			.cmd_request    (cu_cmd_request[i]),
			.cmd_address    (cu_cmd_address[i]),
			.vertex_count   (cu_vertex_count[i]),
			.edge_count     (cu_edge_count[i])
		);
	end

	read_command_port cmd_port (
		.clock            (clock),
		.rstn             (rstn),
		.enabled          (enabled),
		.read_stall       (read_stall),
		.cu_cmd_request   (cu_cmd_request),
		.cu_cmd_address   (cu_cmd_address),
		.cu_cmd_grant     (cu_cmd_grant),
		.read_cmd_valid   (read_cmd_valid),
		.read_cmd_cu_id   (read_cmd_cu_id),
		.read_cmd_address (read_cmd_address)
	);

	read_data_router data_router (
		.clock           (clock),
		.rstn            (rstn),
		.read_data_valid (read_data_valid),
		.read_data_cu_id (read_data_cu_id),
		.cu_data_valid   (cu_data_valid)
	);

	//////////////////////////////////////////////////
	// Done counters
	//////////////////////////////////////////////////

	always_comb begin
		vertex_sum = '0;
		edge_sum   = '0;
		for (int i = 0; i < `NUM_CU; i++) begin
			vertex_sum = vertex_sum + cu_vertex_count[i];
			edge_sum   = edge_sum + cu_edge_count[i];
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_done_count <= '0;
			edge_done_count   <= '0;
		end else begin
			vertex_done_count <= vertex_sum;
			edge_done_count   <= edge_sum;
		end
	end

	// Memory side must return a defined beat
	assert property (@(posedge clock) disable iff (!rstn)
		read_data_valid |-> !$isunknown({read_data_cu_id, read_data_value}))
		else $error("undefined read data beat");

endmodule

`default_nettype wire

// ==== src/graph_cu_pkg.sv ====
//////////////////////////////////////////////////
// Shared types of the graph-engine control unit
// Width typedefs and the compute unit state
//////////////////////////////////////////////////

`default_nettype none

`include "graph_cu_config.svh"

package graph_cu_pkg;

	// Field words
	typedef logic [`CU_ID_BITS-1:0]      cu_id_t;
	typedef logic [`VERTEX_ID_BITS-1:0]  vertex_id_t;
	typedef logic [`EDGE_COUNT_BITS-1:0] edge_count_t;
	typedef logic [`ADDR_BITS-1:0]       addr_t;
	typedef logic [`DATA_BITS-1:0]       data_t;

	// Done counters, per unit and summed
	typedef logic [`COUNT_BITS-1:0]      count_t;

	// Compute unit FSM
	typedef enum logic [1:0] {
		CU_IDLE   = 2'd0,
		CU_ISSUE  = 2'd1,
		CU_WAIT   = 2'd2,
		CU_RETIRE = 2'd3
	} cu_state_e;

endpackage

`default_nettype wire

// ==== src/job_dispatcher.sv ====
//////////////////////////////////////////////////
// Vertex job buffer and dispatch to compute units
// Active-unit mask and round-robin job arbitration
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "graph_cu_config.svh"

module job_dispatcher
	import graph_cu_pkg::*;
(
	input  logic                 clock,
	input  logic                 rstn,
	input  logic                 enabled,
	input  logic [`CU_ID_BITS:0] active_cu_count,
	input  logic                 job_valid,
	input  vertex_id_t           job_vertex_id,
	input  addr_t                job_edge_base,
	input  edge_count_t          job_edge_count,
	input  logic [`NUM_CU-1:0]   cu_job_request,
	output logic                 job_request,
	output logic [`NUM_CU-1:0]   cu_job_valid,
	output vertex_id_t           cu_job_vertex_id,
	output addr_t                cu_job_edge_base,
	output edge_count_t          cu_job_edge_count
);
	localparam int JOB_BITS = `VERTEX_ID_BITS + `ADDR_BITS + `EDGE_COUNT_BITS;

	logic [`CU_ID_BITS:0] active_latched;
	logic [`NUM_CU-1:0]   cu_enable;
	logic [`NUM_CU-1:0]   dispatch_request;
	logic [`NUM_CU-1:0]   dispatch_grant;
	logic [JOB_BITS-1:0]  job_in;
	logic [JOB_BITS-1:0]  job_head;
	logic                 job_empty;
	logic                 job_almost_full;

	//////////////////////////////////////////////////
	// Active units
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			active_latched <= '0;
		end else if (enabled && (active_cu_count != '0)) begin
			active_latched <= active_cu_count;
		end
	end

	// Units whose job is still on its way are left out
	always_comb begin
		for (int i = 0; i < `NUM_CU; i++) begin
			cu_enable[i]        = enabled && ((`CU_ID_BITS+1)'(i) < active_latched);
			dispatch_request[i] = cu_enable[i] && cu_job_request[i] && !cu_job_valid[i]
				&& !job_empty;
		end
	end

	//////////////////////////////////////////////////
	// Job buffer and arbitration
	//////////////////////////////////////////////////

	assign job_in      = {job_vertex_id, job_edge_base, job_edge_count};
	assign job_request = !job_almost_full;

	sync_fifo #(
		.WIDTH    (JOB_BITS),
		.DEPTH    (`JOB_FIFO_DEPTH),
		.HEADROOM (`JOB_FIFO_HEADROOM)
	) job_fifo (
		.clock       (clock),
		.rstn        (rstn),
		.push        (job_valid),
		.data_in     (job_in),
		.pop         (|dispatch_grant),
		.data_out    (job_head),
		.full        (),
		.almost_full (job_almost_full),
		.empty       (job_empty)
	);

	round_robin_arbiter #(
		.NUM_REQUESTS (`NUM_CU)
	) job_arbiter (
		.clock    (clock),
		.rstn     (rstn),
		.requests (dispatch_request),
		.grant    (dispatch_grant)
	);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cu_job_valid <= '0;
		end else begin
			cu_job_valid <= dispatch_grant;
		end
	end

	always_ff @(posedge clock) begin
		if (|dispatch_grant) begin
			{cu_job_vertex_id, cu_job_edge_base, cu_job_edge_count} <= job_head;
		end
	end

endmodule

`default_nettype wire

// ==== src/read_command_port.sv ====
//////////////////////////////////////////////////
// Shared read command port, round-robin over units
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "graph_cu_config.svh"

module read_command_port
	import graph_cu_pkg::*;
(
	input  logic               clock,
	input  logic               rstn,
	input  logic               enabled,
	input  logic               read_stall,
	input  logic [`NUM_CU-1:0] cu_cmd_request,
	input  addr_t              cu_cmd_address [`NUM_CU],
	output logic [`NUM_CU-1:0] cu_cmd_grant,
	output logic               read_cmd_valid,
	output cu_id_t             read_cmd_cu_id,
	output addr_t              read_cmd_address
);
	logic [`NUM_CU-1:0] masked_request;
	cu_id_t             grant_id;
	addr_t              grant_address;

	// No grant while stalled, requests stay up in the units
	assign masked_request = cu_cmd_request & {`NUM_CU{enabled && !read_stall}};

	round_robin_arbiter #(
		.NUM_REQUESTS (`NUM_CU)
	) cmd_arbiter (
		.clock    (clock),
		.rstn     (rstn),
		.requests (masked_request),
		.grant    (cu_cmd_grant)
	);

	always_comb begin
		grant_id      = '0;
		grant_address = '0;
		for (int i = 0; i < `NUM_CU; i++) begin
			if (cu_cmd_grant[i]) begin
				grant_id      = cu_id_t'(i);
				grant_address = cu_cmd_address[i];
			end
		end
	end

	// Output register
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_cmd_valid <= 1'b0;
		end else begin
			read_cmd_valid <= |cu_cmd_grant;
		end
	end

	always_ff @(posedge clock) begin
		read_cmd_cu_id   <= grant_id;
		read_cmd_address <= grant_address;
	end

endmodule

`default_nettype wire

// ==== src/read_data_router.sv ====
//////////////////////////////////////////////////
// Read data return, steered by unit id
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "graph_cu_config.svh"

module read_data_router
	import graph_cu_pkg::*;
(
	input  logic               clock,
	input  logic               rstn,
	input  logic               read_data_valid,
	input  cu_id_t             read_data_cu_id,
	output logic [`NUM_CU-1:0] cu_data_valid
);
	logic [`NUM_CU-1:0] decoded_valid;

	// Not gated by enable, beats in flight still land
	always_comb begin
		for (int i = 0; i < `NUM_CU; i++) begin
			decoded_valid[i] = read_data_valid && (read_data_cu_id == cu_id_t'(i));
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cu_data_valid <= '0;
		end else begin
			cu_data_valid <= decoded_valid;
		end
	end

endmodule

`default_nettype wire

// ==== src/round_robin_arbiter.sv ====
//////////////////////////////////////////////////
// Round-robin arbiter, one-hot grant
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module round_robin_arbiter #(
	parameter int NUM_REQUESTS = 4
) (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic [NUM_REQUESTS-1:0] requests,
	output logic [NUM_REQUESTS-1:0] grant
);
	localparam int IDX_BITS = (NUM_REQUESTS > 1) ? $clog2(NUM_REQUESTS) : 1;

	logic [IDX_BITS-1:0] last_winner;
	logic [IDX_BITS-1:0] next_winner;

	// Search starts one past the last winner
	always_comb begin
		int unsigned idx;
		grant       = '0;
		next_winner = last_winner;
		for (int off = 1; off <= NUM_REQUESTS; off++) begin
			idx = (int'(last_winner) + off) % NUM_REQUESTS;
			if (requests[idx] && (grant == '0)) begin
				grant[idx]  = 1'b1;
				next_winner = IDX_BITS'(idx);
			end
		end
	end

	// Start so that requester 0 wins first
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			last_winner <= IDX_BITS'(NUM_REQUESTS-1);
		end else if (|requests) begin
			last_winner <= next_winner;
		end
	end

	assert property (@(posedge clock) disable iff (!rstn) $onehot0(grant))
		else $error("arbiter grant is not one-hot");

endmodule

`default_nettype wire

// ==== src/sync_fifo.sv ====
//////////////////////////////////////////////////
// Synchronous FIFO, head entry shown on data_out
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module sync_fifo #(
	parameter int WIDTH    = 8,
	parameter int DEPTH    = 8,
	parameter int HEADROOM = 2
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             full,
	output logic             almost_full,
	output logic             empty
);
	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [WIDTH-1:0]    mem [DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [PTR_BITS:0]   level;
	logic                do_push;
	logic                do_pop;

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign data_out    = mem[rd_ptr];
	assign full        = (level == (PTR_BITS+1)'(DEPTH));
	assign empty       = (level == '0);
	// Fewer than HEADROOM free slots left
	assign almost_full = (level > (PTR_BITS+1)'(DEPTH - HEADROOM));

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
			end
			level <= level + do_push - do_pop;
		end
	end

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	// Producer and consumer must respect the flags
	assert property (@(posedge clock) disable iff (!rstn) push |-> !full)
		else $error("push into full FIFO");
	assert property (@(posedge clock) disable iff (!rstn) pop |-> !empty)
		else $error("pop from empty FIFO");

endmodule

`default_nettype wire

// ==== src/vertex_cu.sv ====
//////////////////////////////////////////////////
// Vertex compute unit
// One read per edge, job retires on last beat
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module vertex_cu
	import graph_cu_pkg::*;
(
	input  logic        clock,
	input  logic        rstn,
	input  logic        job_valid,
	input  vertex_id_t  job_vertex_id,
	input  addr_t       job_edge_base,
	input  edge_count_t job_edge_count,
	input  logic        cmd_grant,
	input  logic        data_valid,
	output logic        job_request,
	output logic        cmd_request,
	output addr_t       cmd_address,
	output count_t      vertex_count,
	output count_t      edge_count
);
	cu_state_e   state;
	vertex_id_t  vertex_id;
	addr_t       edge_base;
	edge_count_t edges;
	edge_count_t issued;
	edge_count_t returned;
	edge_count_t returned_next;
	edge_count_t issued_next;

	assign returned_next = returned + edge_count_t'(data_valid);
	assign issued_next   = issued + 1'b1;

	assign job_request = (state == CU_IDLE);
	assign cmd_request = (state == CU_ISSUE);
	// Reads walk the edge list from its base
	assign cmd_address = edge_base + addr_t'(issued);

	//////////////////////////////////////////////////
	// Control FSM
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state        <= CU_IDLE;
			issued       <= '0;
			returned     <= '0;
			vertex_count <= '0;
			edge_count   <= '0;
		end else begin
			case (state)
				CU_IDLE: begin
					issued   <= '0;
					returned <= '0;
					if (job_valid) begin
						state <= (job_edge_count == '0) ? CU_RETIRE : CU_ISSUE;
					end
				end
				CU_ISSUE: begin
					// Early beats may come back while still issuing
					returned <= returned_next;
					if (cmd_grant) begin
						issued <= issued_next;
						if (issued_next == edges) begin
							state <= CU_WAIT;
						end
					end
				end
				CU_WAIT: begin
					returned <= returned_next;
					if (returned_next == edges) begin
						state <= CU_RETIRE;
					end
				end
				CU_RETIRE: begin
					vertex_count <= vertex_count + 1'b1;
					edge_count   <= edge_count + count_t'(edges);
					state        <= CU_IDLE;
				end
				default: begin
					state <= CU_IDLE;
				end
			endcase
		end
	end

	// Job fields held for the life of the job
	always_ff @(posedge clock) begin
		if ((state == CU_IDLE) && job_valid) begin
			vertex_id <= job_vertex_id;
			edge_base <= job_edge_base;
			edges     <= job_edge_count;
		end
	end

	// Router must only deliver beats this unit asked for
	assert property (@(posedge clock) disable iff (!rstn) data_valid |-> (state != CU_IDLE))
		else $error("read beat for idle unit, last vertex %0h", vertex_id);

endmodule

`default_nettype wire

// ==== verification/graph_cu_control_tb.sv ====
//////////////////////////////////////////////////
// Testbench for the graph-engine control unit
// Directed tests, read memory model, timeout
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "graph_cu_config.svh"

module graph_cu_control_tb
	import graph_cu_pkg::*;
;
	localparam addr_t MEM_BASE       = 32'h0010_0000;
	localparam int    MEM_SLOTS      = 16384;
	localparam int    TIMEOUT_CYCLES = 4000;

	logic                 clock;
	logic                 rstn;
	logic                 enabled_in;
	logic [`CU_ID_BITS:0] active_cu_count;
	logic                 job_valid;
	vertex_id_t           job_vertex_id;
	addr_t                job_edge_base;
	edge_count_t          job_edge_count;
	logic                 job_request;
	logic                 read_stall;
	logic                 read_cmd_valid;
	cu_id_t               read_cmd_cu_id;
	addr_t                read_cmd_address;
	logic                 read_data_valid;
	cu_id_t               read_data_cu_id;
	data_t                read_data_value;
	count_t               vertex_done_count;
	count_t               edge_done_count;

	integer      seed;
	int          cycles;
	int          next_vertex;
	count_t      exp_vertex;
	count_t      exp_edge;
	addr_t       exp_base [$];
	int          exp_edges [$];
	addr_t       cmd_addr_log [$];
	cu_id_t      cmd_id_log [$];
	int          read_count [MEM_SLOTS];
	cu_id_t      pend_id [$];
	int          pend_delay [$];

	graph_cu_control UUT (
		.clock             (clock),
		.rstn              (rstn),
		.enabled_in        (enabled_in),
		.active_cu_count   (active_cu_count),
		.job_valid         (job_valid),
		.job_vertex_id     (job_vertex_id),
		.job_edge_base     (job_edge_base),
		.job_edge_count    (job_edge_count),
		.job_request       (job_request),
		.read_stall        (read_stall),
		.read_cmd_valid    (read_cmd_valid),
		.read_cmd_cu_id    (read_cmd_cu_id),
		.read_cmd_address  (read_cmd_address),
		.read_data_valid   (read_data_valid),
		.read_data_cu_id   (read_data_cu_id),
		.read_data_value   (read_data_value),
		.vertex_done_count (vertex_done_count),
		.edge_done_count   (edge_done_count)
	);

	always #5 clock = ~clock;

	// Roughly twice the length of all tests
	always @(posedge clock) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("SOME TESTS FAILED");
			$fatal(1);
		end
	end

	task automatic check(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Error: %s is %h, expected %h", name, actual, expected);
			$display("SOME TESTS FAILED");
			$fatal(1);
		end
	endtask

	//////////////////////////////////////////////////
	// Memory model
	//////////////////////////////////////////////////

	// Each command answers after 0 to 7 cycles, one beat per cycle
	always @(negedge clock) begin
		int slot;
		slot = -1;
		read_data_valid = 1'b0;
		for (int i = 0; i < pend_delay.size(); i++) begin
			if (pend_delay[i] > 0) begin
				pend_delay[i] = pend_delay[i] - 1;
			end else if (slot < 0) begin
				slot = i;
			end
		end
		if (slot >= 0) begin
			read_data_valid = 1'b1;
			read_data_cu_id = pend_id[slot];
			read_data_value = $random(seed);
			pend_id.delete(slot);
			pend_delay.delete(slot);
		end
		if (rstn && read_cmd_valid) begin
			check("read_cmd_address in range", (read_cmd_address >= MEM_BASE)
				&& (read_cmd_address < MEM_BASE + MEM_SLOTS), 1);
			cmd_addr_log.push_back(read_cmd_address);
			cmd_id_log.push_back(read_cmd_cu_id);
			read_count[read_cmd_address - MEM_BASE]++;
			pend_id.push_back(read_cmd_cu_id);
			pend_delay.push_back({$random(seed)} % 8);
		end
	end

	//////////////////////////////////////////////////
	// Job helpers
	//////////////////////////////////////////////////

	task automatic clear_logs();
		cmd_addr_log = {};
		cmd_id_log = {};
		exp_base = {};
		exp_edges = {};
		for (int i = 0; i < MEM_SLOTS; i++) begin
			read_count[i] = 0;
		end
	endtask

	// Each vertex owns 256 addresses, so an address names its job
	task automatic push_job(input edge_count_t edges);
		addr_t base;
		base = MEM_BASE + addr_t'(next_vertex << 8);
		while (!job_request) begin
			@(negedge clock);
		end
		job_valid      = 1'b1;
		job_vertex_id  = vertex_id_t'(next_vertex);
		job_edge_base  = base;
		job_edge_count = edges;
		@(negedge clock);
		job_valid = 1'b0;
		next_vertex++;
		exp_vertex = exp_vertex + 1'b1;
		exp_edge   = exp_edge + count_t'(edges);
		exp_base.push_back(base);
		exp_edges.push_back(edges);
	endtask

	task automatic wait_jobs_done();
		int total;
		total = 0;
		while (vertex_done_count < exp_vertex) begin
			@(negedge clock);
		end
		check("vertex_done_count", vertex_done_count, exp_vertex);
		check("edge_done_count", edge_done_count, exp_edge);
		for (int j = 0; j < exp_base.size(); j++) begin
			for (int e = 0; e < exp_edges[j]; e++) begin
				check($sformatf("reads of address %h", exp_base[j] + e),
					read_count[exp_base[j] + e - MEM_BASE], 1);
			end
			total += exp_edges[j];
		end
		check("read_cmd_valid count", cmd_addr_log.size(), total);
	endtask

	//////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////

	task automatic test_reset_state();
		check("read_cmd_valid", read_cmd_valid, 0);
		check("vertex_done_count", vertex_done_count, 0);
		check("edge_done_count", edge_done_count, 0);
		check("job_request", job_request, 1);
	endtask

	task automatic test_single_job();
		clear_logs();
		push_job(3);
		wait_jobs_done();
		check("read_cmd_valid count", cmd_addr_log.size(), 3);
		for (int i = 0; i < 3; i++) begin
			check("read_cmd_address", cmd_addr_log[i], exp_base[0] + i);
			check("read_cmd_cu_id", cmd_id_log[i], cmd_id_log[0]);
		end
	endtask

	task automatic test_active_units();
		active_cu_count = 2;
		@(negedge clock);
		clear_logs();
		// First job has no edges
		for (int i = 0; i < 12; i++) begin
			push_job(edge_count_t'((i * 5) % 9));
		end
		wait_jobs_done();
		for (int i = 0; i < cmd_id_log.size(); i++) begin
			check("read_cmd_cu_id below 2", cmd_id_log[i] < 2, 1);
		end
		active_cu_count = 4;
		@(negedge clock);
	endtask

	task automatic test_read_stall();
		int stall_cmds;
		stall_cmds = 0;
		clear_logs();
		for (int i = 0; i < 8; i++) begin
			push_job(6);
		end
		while (!read_cmd_valid) begin
			@(negedge clock);
		end
		read_stall = 1'b1;
		repeat (20) begin
			@(negedge clock);
			if (read_cmd_valid) begin
				stall_cmds++;
			end
		end
		read_stall = 1'b0;
		check("at most one read_cmd_valid during stall", stall_cmds <= 1, 1);
		wait_jobs_done();
	endtask

	task automatic test_disabled_push();
		enabled_in = 1'b0;
		repeat (2) @(negedge clock);
		clear_logs();
		push_job(2);
		push_job(5);
		push_job(0);
		push_job(7);
		repeat (20) @(negedge clock);
		check("read_cmd_valid count while disabled", cmd_addr_log.size(), 0);
		check("vertex_done_count while disabled", vertex_done_count, exp_vertex - 4);
		enabled_in = 1'b1;
		wait_jobs_done();
	endtask

	task automatic test_random_jobs();
		edge_count_t edges [20];
		clear_logs();
		// Drawn up front while the memory model is quiet
		for (int i = 0; i < 20; i++) begin
			edges[i] = edge_count_t'({$random(seed)} % 16);
		end
		for (int i = 0; i < 20; i++) begin
			push_job(edges[i]);
		end
		wait_jobs_done();
	endtask

	initial begin
		seed            = 32'h25ba_846e;
		cycles          = 0;
		next_vertex     = 0;
		exp_vertex      = '0;
		exp_edge        = '0;
		clock           = 1'b0;
		rstn            = 1'b0;
		enabled_in      = 1'b0;
		active_cu_count = 4;
		job_valid       = 1'b0;
		job_vertex_id   = '0;
		job_edge_base   = '0;
		job_edge_count  = '0;
		read_stall      = 1'b0;
		read_data_valid = 1'b0;
		read_data_cu_id = '0;
		read_data_value = '0;
		repeat (2) @(negedge clock);
		rstn = 1'b1;
		@(negedge clock);
		test_reset_state();
		enabled_in = 1'b1;
		repeat (2) @(negedge clock);
		test_single_job();
		test_active_units();
		test_read_stall();
		test_disabled_push();
		test_random_jobs();
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire
